//--- logic/procPkg.sv
/*
   Shared widths, opcodes and control encodings for the 16-bit single-cycle core.
   Every design file refers to these by scoped name, procPkg::name.
*/
package procPkg;

   // basic widths
   typedef logic [15:0] word_t;
   typedef logic [2:0]  regAddr_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [1:0]  aluOp_t;
   typedef logic [2:0]  setKind_t;
   typedef logic [2:0]  brKind_t;

   localparam int NUM_REGS   = 8;
   localparam int DMEM_WORDS = 256;
   // word index width, byte address bit 0 is dropped
   localparam int DMEM_AW    = $clog2(DMEM_WORDS);

   // alu functions
   localparam aluOp_t ALU_ADD   = 2'd0;
   localparam aluOp_t ALU_XOR   = 2'd1;
   localparam aluOp_t ALU_ANDN  = 2'd2;
   localparam aluOp_t ALU_PASSB = 2'd3;

   // opcodes, instruction bits 15:11
   localparam opcode_t OP_HALT  = 5'b00000;
   localparam opcode_t OP_NOP   = 5'b00001;
   localparam opcode_t OP_J     = 5'b00100;
   localparam opcode_t OP_JR    = 5'b00101;
   localparam opcode_t OP_JAL   = 5'b00110;
   localparam opcode_t OP_ADDI  = 5'b01000;
   localparam opcode_t OP_SUBI  = 5'b01001;
   localparam opcode_t OP_XORI  = 5'b01010;
   localparam opcode_t OP_ANDNI = 5'b01011;
   localparam opcode_t OP_BEQZ  = 5'b01100;
   localparam opcode_t OP_BNEZ  = 5'b01101;
   localparam opcode_t OP_BLTZ  = 5'b01110;
   localparam opcode_t OP_BGEZ  = 5'b01111;
   localparam opcode_t OP_ST    = 5'b10000;
   localparam opcode_t OP_LD    = 5'b10001;
   localparam opcode_t OP_SLBI  = 5'b10010;
   localparam opcode_t OP_LBI   = 5'b11000;
   localparam opcode_t OP_BTR   = 5'b11001;
   // register alu ops, function in bits 1:0 (add, sub, xor, andn)
   localparam opcode_t OP_ALU   = 5'b11011;
   localparam opcode_t OP_SEQ   = 5'b11100;
   localparam opcode_t OP_SLT   = 5'b11101;
   localparam opcode_t OP_SLE   = 5'b11110;
   localparam opcode_t OP_SCO   = 5'b11111;

   // compare kinds
   localparam setKind_t SET_NONE = 3'd0;
   localparam setKind_t SET_EQ   = 3'd1;
   localparam setKind_t SET_LT   = 3'd2;
   localparam setKind_t SET_LE   = 3'd3;
   localparam setKind_t SET_CO   = 3'd4;

   // branch kinds
   localparam brKind_t BR_NONE = 3'd0;
   localparam brKind_t BR_EQZ  = 3'd1;
   localparam brKind_t BR_NEZ  = 3'd2;
   localparam brKind_t BR_LTZ  = 3'd3;
   localparam brKind_t BR_GEZ  = 3'd4;

   // decoded control for one instruction
   typedef struct packed {
      aluOp_t   aluOp;
      logic     invA;
      logic     invB;
      logic     useImm;
      logic     slbi;
      logic     btr;
      setKind_t setKind;
      brKind_t  branchKind;
      logic     jump;
      logic     jumpReg;
      logic     link;
      logic     memRead;
      logic     memWrite;
      logic     regWrite;
      regAddr_t writeReg;
      logic     halt;
   } ctrl_t;

   // what execute hands on to the result stage and the pc
   typedef struct packed {
      word_t value;
      word_t storeData;
      word_t nextPc;
      word_t linkPc;
   } exResult_t;

endpackage

//--- logic/regFile.sv
/*
   Eight 16-bit general registers, two combinational read ports and one write port.
   No reset, software sets registers up with LBI.
*/
`timescale 1ns/1ps

module regFile (
   input  logic             clk,
   input  logic             wrEn,
   input  procPkg::regAddr_t wrReg,
   input  procPkg::word_t   wrData,
   input  procPkg::regAddr_t rdRegA,
   input  procPkg::regAddr_t rdRegB,
   output procPkg::word_t   rdDataA,
   output procPkg::word_t   rdDataB
);

   procPkg::word_t regs [procPkg::NUM_REGS];

   // write lands at the edge, visible to reads in the next cycle
   always_ff @(posedge clk) begin
      if (wrEn) begin
         regs[wrReg] <= wrData;
      end
   end

   // reads are plain muxes, no bypass needed in a single cycle core
   assign rdDataA = regs[rdRegA];
   assign rdDataB = regs[rdRegB];

endmodule

//--- logic/alu.sv
/*
   16-bit ALU. Either input may be inverted before the adder or logic op,
   so subtraction is ~a + b + 1. Flags cover zero, carry out and signed overflow.
*/
`timescale 1ns/1ps

module alu (
   input  procPkg::word_t  a,
   input  procPkg::word_t  b,
   input  procPkg::aluOp_t op,
   input  logic            invA,
   input  logic            invB,
   input  logic            cin,
   output procPkg::word_t  out,
   output logic            zero,
   output logic            carry,
   output logic            ofl
);

   procPkg::word_t inA, inB;
   logic [16:0]    sum;

   assign inA = invA ? ~a : a;
   assign inB = invB ? ~b : b;

   // one extra bit holds the carry
   assign sum = {1'b0, inA} + {1'b0, inB} + {16'b0, cin};

   always_comb begin
      case (op)
         procPkg::ALU_XOR:  out = inA ^ inB;
         procPkg::ALU_ANDN: out = inA & ~inB;
         procPkg::ALU_PASSB: out = inB;
         default:           out = sum[15:0];
      endcase
   end

   assign zero  = (out == '0);
   assign carry = sum[16];
   // same signs in, different sign out
   assign ofl   = (inA[15] == inB[15]) && (sum[15] != inA[15]);

endmodule

//--- logic/decode.sv
/*
   Decode stage. Maps the opcode to the control struct, builds the immediate
   and reads rs (bits 10:8) and rt (bits 7:5) from the register file.
*/
`timescale 1ns/1ps

module decode (
   input  logic              clk,
   input  procPkg::word_t    instr,
   input  logic              wrEn,
   input  procPkg::regAddr_t wrReg,
   input  procPkg::word_t    wrData,
   output procPkg::ctrl_t    ctrl,
   output procPkg::word_t    rsData,
   output procPkg::word_t    rtData,
   output procPkg::word_t    imm
);

   procPkg::opcode_t op;
   procPkg::word_t   imm5s, imm5z, imm8s, imm8z, imm11s;

   assign op = instr[15:11];

   // immediate fields in both extensions
   assign imm5s  = {{11{instr[4]}}, instr[4:0]};
   assign imm5z  = {11'b0, instr[4:0]};
   assign imm8s  = {{8{instr[7]}}, instr[7:0]};
   assign imm8z  = {8'b0, instr[7:0]};
   assign imm11s = {{5{instr[10]}}, instr[10:0]};

   regFile regs (
      .clk(clk), .wrEn(wrEn), .wrReg(wrReg), .wrData(wrData),
      .rdRegA(instr[10:8]), .rdRegB(instr[7:5]),
      .rdDataA(rsData), .rdDataB(rtData)
   );

   always_comb begin
      // default is a nop that adds
      ctrl = '0;
      ctrl.aluOp = procPkg::ALU_ADD;
      ctrl.setKind = procPkg::SET_NONE;
      ctrl.branchKind = procPkg::BR_NONE;
      imm = '0;
      case (op)
         procPkg::OP_HALT:  ctrl.halt = 1'b1;
         procPkg::OP_ADDI,
         procPkg::OP_SUBI,
         procPkg::OP_XORI,
         procPkg::OP_ANDNI,
         procPkg::OP_LD: begin
            // I-format 1, rd in bits 7:5
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.writeReg = instr[7:5];
            ctrl.invA = (op == procPkg::OP_SUBI);
            ctrl.memRead = (op == procPkg::OP_LD);
            if (op == procPkg::OP_XORI) ctrl.aluOp = procPkg::ALU_XOR;
            if (op == procPkg::OP_ANDNI) ctrl.aluOp = procPkg::ALU_ANDN;
            imm = (op == procPkg::OP_XORI || op == procPkg::OP_ANDNI) ? imm5z : imm5s;
         end
         procPkg::OP_ST: begin
            // stored value comes from rt port (bits 7:5)
            ctrl.useImm = 1'b1;
            ctrl.memWrite = 1'b1;
            imm = imm5s;
         end
         procPkg::OP_ALU, procPkg::OP_BTR,
         procPkg::OP_SEQ, procPkg::OP_SLT, procPkg::OP_SLE, procPkg::OP_SCO: begin
            // R-format, rd in bits 4:2
            ctrl.regWrite = 1'b1;
            ctrl.writeReg = instr[4:2];
            ctrl.btr = (op == procPkg::OP_BTR);
            case (op)
               procPkg::OP_SEQ: ctrl.setKind = procPkg::SET_EQ;
               procPkg::OP_SLT: ctrl.setKind = procPkg::SET_LT;
               procPkg::OP_SLE: ctrl.setKind = procPkg::SET_LE;
               procPkg::OP_SCO: ctrl.setKind = procPkg::SET_CO;
               default: ;
            endcase
            // compares except sco run rs minus rt
            ctrl.invB = (op == procPkg::OP_SEQ || op == procPkg::OP_SLT ||
                         op == procPkg::OP_SLE);
            if (op == procPkg::OP_ALU) begin
               case (instr[1:0])
                  2'b01:   ctrl.invA = 1'b1;
                  2'b10:   ctrl.aluOp = procPkg::ALU_XOR;
                  2'b11:   ctrl.aluOp = procPkg::ALU_ANDN;
                  default: ctrl.aluOp = procPkg::ALU_ADD;
               endcase
            end
         end
         procPkg::OP_BEQZ: begin ctrl.branchKind = procPkg::BR_EQZ; imm = imm8s; end
         procPkg::OP_BNEZ: begin ctrl.branchKind = procPkg::BR_NEZ; imm = imm8s; end
         procPkg::OP_BLTZ: begin ctrl.branchKind = procPkg::BR_LTZ; imm = imm8s; end
         procPkg::OP_BGEZ: begin ctrl.branchKind = procPkg::BR_GEZ; imm = imm8s; end
         procPkg::OP_LBI, procPkg::OP_SLBI: begin
            // rs is also the destination
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.writeReg = instr[10:8];
            ctrl.slbi = (op == procPkg::OP_SLBI);
            ctrl.aluOp = (op == procPkg::OP_LBI) ? procPkg::ALU_PASSB : procPkg::ALU_ADD;
            imm = (op == procPkg::OP_SLBI) ? imm8z : imm8s;
         end
         procPkg::OP_J: begin ctrl.jump = 1'b1; imm = imm11s; end
         procPkg::OP_JAL: begin
            ctrl.jump = 1'b1;
            ctrl.link = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.writeReg = 3'd7;
            imm = imm11s;
         end
         procPkg::OP_JR: begin
            // target is rs plus imm, computed by the alu
            ctrl.jump = 1'b1;
            ctrl.jumpReg = 1'b1;
            ctrl.useImm = 1'b1;
            imm = imm8s;
         end
         default: ;  // nop and unused opcodes
      endcase
   end

endmodule

//--- logic/execute.sv
/*
   Execute stage. Picks the ALU operands, forms compare and bit-reverse results
   and resolves the next pc for branches and jumps.
*/
`timescale 1ns/1ps

module execute (
   input  procPkg::ctrl_t     ctrl,
   input  procPkg::word_t     rsData,
   input  procPkg::word_t     rtData,
   input  procPkg::word_t     imm,
   input  procPkg::word_t     pc,
   output procPkg::exResult_t ex
);

   procPkg::word_t opA, opB, aluOut, revA, pcInc, target;
   logic           zero, carry, ofl, lt, setBit, taken;

   // slbi shifts rs up, the byte is added in below
   assign opA = ctrl.slbi ? (rsData << 8) : rsData;
   // branches test rs against zero
   assign opB = (ctrl.branchKind != procPkg::BR_NONE) ? '0 :
                ctrl.useImm ? imm : rtData;

   alu aluInst (
      .a(opA), .b(opB), .op(ctrl.aluOp),
      .invA(ctrl.invA), .invB(ctrl.invB), .cin(ctrl.invA | ctrl.invB),
      .out(aluOut), .zero(zero), .carry(carry), .ofl(ofl)
   );

   // signed less-than from the a-b result
   assign lt = aluOut[15] ^ ofl;

   always_comb begin
      case (ctrl.setKind)
         procPkg::SET_EQ: setBit = zero;
         procPkg::SET_LT: setBit = lt;
         procPkg::SET_LE: setBit = lt | zero;
         procPkg::SET_CO: setBit = carry;
         default:         setBit = 1'b0;
      endcase
   end

   always_comb begin
      for (int i = 0; i < 16; i++) begin
         revA[i] = rsData[15 - i];
      end
   end

   always_comb begin
      case (ctrl.branchKind)
         procPkg::BR_EQZ: taken = zero;
         procPkg::BR_NEZ: taken = ~zero;
         procPkg::BR_LTZ: taken = aluOut[15];
         procPkg::BR_GEZ: taken = ~aluOut[15];
         default:         taken = 1'b0;
      endcase
   end

   assign pcInc  = pc + 16'd2;
   assign target = pcInc + imm;

   assign ex.value = (ctrl.setKind != procPkg::SET_NONE) ? {15'b0, setBit} :
                     ctrl.btr ? revA : aluOut;
   assign ex.storeData = rtData;
   // jr uses the alu sum rs + imm
   assign ex.nextPc = ctrl.jumpReg ? aluOut :
                      (ctrl.jump | taken) ? target : pcInc;
   assign ex.linkPc = pcInc;

endmodule

//--- logic/result.sv
/*
   Memory and writeback. Holds the data memory, word addressed by byte address
   bits 8:1, and chooses what goes back to the register file.
*/
`timescale 1ns/1ps

module result (
   input  logic               clk,
   input  logic               rstN,
   input  procPkg::ctrl_t     ctrl,
   input  procPkg::exResult_t ex,
   input  logic               halted,
   output logic               wbEn,
   output procPkg::regAddr_t  wbReg,
   output procPkg::word_t     wbData
);

   procPkg::word_t             dmem [procPkg::DMEM_WORDS];
   logic [procPkg::DMEM_AW-1:0] addr;
   procPkg::word_t             loadData;
   logic                       live;

   // no writes of any kind in reset or after halt
   assign live = rstN & ~halted;

   assign addr = ex.value[procPkg::DMEM_AW:1];

   always_ff @(posedge clk) begin
      if (ctrl.memWrite && live) begin
         dmem[addr] <= ex.storeData;
      end
   end

   // loads read through in the same cycle
   assign loadData = dmem[addr];

   assign wbEn   = ctrl.regWrite & live;
   assign wbReg  = ctrl.writeReg;
   assign wbData = ctrl.memRead ? loadData :
                   ctrl.link    ? ex.linkPc : ex.value;

endmodule

//--- logic/proc.sv
/*
   Top of the single-cycle core. Holds the pc and halt flag and wires
   decode, execute and result. The instruction port is read combinationally.
*/
`timescale 1ns/1ps

module proc (
   input  logic              clk,
   input  logic              rstN,
   input  procPkg::word_t    instr,
   output procPkg::word_t    imemAddr,
   output logic              wbEn,
   output procPkg::regAddr_t wbReg,
   output procPkg::word_t    wbData,
   output logic              halted
);

   procPkg::word_t     pc;
   procPkg::ctrl_t     ctrl;
   procPkg::word_t     rsData, rtData, imm;
   procPkg::exResult_t ex;

   assign imemAddr = pc;

   // pc moves every edge until halt; halt freezes it until reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
         halted <= 1'b0;
      end else if (!halted) begin
         if (ctrl.halt) begin
            halted <= 1'b1;
         end else begin
            pc <= ex.nextPc;
         end
      end
   end

   decode decodeInst (
      .clk(clk), .instr(instr),
      .wrEn(wbEn), .wrReg(wbReg), .wrData(wbData),
      .ctrl(ctrl), .rsData(rsData), .rtData(rtData), .imm(imm)
   );

   execute executeInst (
      .ctrl(ctrl), .rsData(rsData), .rtData(rtData), .imm(imm), .pc(pc), .ex(ex)
   );

   result resultInst (
      .clk(clk), .rstN(rstN), .ctrl(ctrl), .ex(ex), .halted(halted),
      .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
   );

endmodule

//--- test/proc_assertions.sv
/*
   Concurrent checks on reset, halt and writeback of the core.
   Bound into every proc instance by the bind at the end.
*/
`timescale 1ns/1ps

module procAssertions (
   input logic           clk,
   input logic           rstN,
   input logic           wbEn,
   input procPkg::word_t imemAddr,
   input logic           halted
);

   // nothing is written while reset is held
   resetQuiet: assert property (@(posedge clk) !rstN |-> !wbEn)
      else $error("wbEn high while rstN is low");

   // pc frozen once halted, until reset
   haltHoldsPc: assert property (
      @(posedge clk) disable iff (!rstN) halted |=> $stable(imemAddr))
      else $error("imemAddr moved while halted");

   haltNoWrite: assert property (@(posedge clk) halted |-> !wbEn)
      else $error("wbEn high while halted");

endmodule

bind proc procAssertions checks (
   .clk(clk), .rstN(rstN), .wbEn(wbEn), .imemAddr(imemAddr), .halted(halted)
);

//--- test/procTb.sv
/*
   Directed testbench for the single-cycle core. Each test loads a program into the
   instruction memory, resets the core and compares the register writes and the pc
   trace with an instruction set model that runs the same program.
*/
`timescale 1ns/1ps

module procTb;

   localparam int CLK_NS       = 10;
   localparam int RESET_CYCLES = 16;
   localparam int MAX_CYCLES   = 64;
   localparam int HOLD_CYCLES  = 4;
   localparam int NUM_TESTS    = 6;
   // all tests at full length plus room for the post-halt cycles
   localparam int WATCHDOG_NS  = NUM_TESTS * (RESET_CYCLES + MAX_CYCLES) * CLK_NS + 5200;

   logic              clk;
   logic              rstN;
   procPkg::word_t    instr;
   procPkg::word_t    imemAddr;
   logic              wbEn;
   procPkg::regAddr_t wbReg;
   procPkg::word_t    wbData;
   logic              halted;

   // instruction memory indexed by imemAddr bits 8:1
   procPkg::word_t imem [256];
   int             progLen;
   integer         seed = 32'h8dffe38f;

   // expected traces from the model
   procPkg::regAddr_t expReg [$];
   procPkg::word_t    expData [$];
   procPkg::word_t    expPc [$];

   int errors;
   int passCount;
   int failCount;

   proc dut (
      .clk(clk), .rstN(rstN), .instr(instr), .imemAddr(imemAddr),
      .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // fetch answers 1 ns after the edge once the pc has settled
   always @(posedge clk) begin
      #1;
      instr = imem[imemAddr[8:1]];
   end

   function automatic procPkg::word_t randWord();
      logic [31:0] raw;
      raw = $random(seed);
      return raw[15:0];
   endfunction

   // instruction formats
   function automatic procPkg::word_t immForm(input procPkg::opcode_t op,
         input logic [2:0] rs, input logic [2:0] rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic procPkg::word_t regForm(input procPkg::opcode_t op,
         input logic [2:0] rs, input logic [2:0] rt, input logic [2:0] rd,
         input logic [1:0] fn);
      return {op, rs, rt, rd, fn};
   endfunction

   function automatic procPkg::word_t byteForm(input procPkg::opcode_t op,
         input logic [2:0] rs, input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic procPkg::word_t jumpForm(input procPkg::opcode_t op,
         input logic [10:0] imm);
      return {op, imm};
   endfunction

   // unused words are HALT with the word index in the low bits
   task automatic newProgram();
      for (int i = 0; i < 256; i++) begin
         imem[i] = {8'h00, 8'(i)};
      end
      progLen = 0;
   endtask

   task automatic put(input procPkg::word_t w);
      imem[progLen] = w;
      progLen++;
   endtask

   // full 16-bit constant as a sign-extended high byte shifted up
   task automatic loadConst(input procPkg::regAddr_t r, input procPkg::word_t v);
      put(byteForm(procPkg::OP_LBI, r, v[15:8]));
      put(byteForm(procPkg::OP_SLBI, r, v[7:0]));
   endtask

   // destination register of an instruction with its write flag in bit 3
   function automatic logic [3:0] destOf(input procPkg::word_t w);
      case (w[15:11])
         procPkg::OP_ADDI, procPkg::OP_SUBI, procPkg::OP_XORI,
         procPkg::OP_ANDNI, procPkg::OP_LD:
            return {1'b1, w[7:5]};
         procPkg::OP_ALU, procPkg::OP_BTR, procPkg::OP_SEQ,
         procPkg::OP_SLT, procPkg::OP_SLE, procPkg::OP_SCO:
            return {1'b1, w[4:2]};
         procPkg::OP_LBI, procPkg::OP_SLBI:
            return {1'b1, w[10:8]};
         procPkg::OP_JAL:
            return {1'b1, 3'd7};
         default:
            return 4'b0;
      endcase
   endfunction

   // value written back under the instruction set rules
   function automatic procPkg::word_t valueOf(input procPkg::word_t w, a, b, pc, ld);
      procPkg::word_t i5s, i5z, i8s, rev;
      logic [16:0]    sum;
      i5s = {{11{w[4]}}, w[4:0]};
      i5z = {11'b0, w[4:0]};
      i8s = {{8{w[7]}}, w[7:0]};
      sum = {1'b0, a} + {1'b0, b};
      for (int k = 0; k < 16; k++) begin
         rev[k] = a[15 - k];
      end
      case (w[15:11])
         procPkg::OP_ADDI:  return a + i5s;
         procPkg::OP_SUBI:  return i5s - a;
         procPkg::OP_XORI:  return a ^ i5z;
         procPkg::OP_ANDNI: return a & ~i5z;
         procPkg::OP_LD:    return ld;
         procPkg::OP_ALU:
            case (w[1:0])
               2'b00:   return a + b;
               2'b01:   return b - a;
               2'b10:   return a ^ b;
               default: return a & ~b;
            endcase
         procPkg::OP_SEQ:   return {15'b0, a == b};
         procPkg::OP_SLT:   return {15'b0, $signed(a) < $signed(b)};
         procPkg::OP_SLE:   return {15'b0, $signed(a) <= $signed(b)};
         procPkg::OP_SCO:   return {15'b0, sum[16]};
         procPkg::OP_BTR:   return rev;
         procPkg::OP_LBI:   return i8s;
         procPkg::OP_SLBI:  return {a[7:0], w[7:0]};
         procPkg::OP_JAL:   return pc + 16'd2;
         default:           return '0;
      endcase
   endfunction

   function automatic procPkg::word_t nextOf(input procPkg::word_t w, a, pc);
      procPkg::word_t i8s, i11s, seq;
      i8s  = {{8{w[7]}}, w[7:0]};
      i11s = {{5{w[10]}}, w[10:0]};
      seq  = pc + 16'd2;
      case (w[15:11])
         procPkg::OP_BEQZ: return (a == 16'd0) ? seq + i8s : seq;
         procPkg::OP_BNEZ: return (a != 16'd0) ? seq + i8s : seq;
         procPkg::OP_BLTZ: return a[15] ? seq + i8s : seq;
         procPkg::OP_BGEZ: return !a[15] ? seq + i8s : seq;
         procPkg::OP_J,
         procPkg::OP_JAL:  return seq + i11s;
         procPkg::OP_JR:   return a + i8s;
         default:          return seq;
      endcase
   endfunction

   // runs the loaded program and fills the expected traces
   task automatic runModel();
      procPkg::word_t r [8];
      procPkg::word_t m [256];
      procPkg::word_t pc, w, a, b, addr;
      logic [3:0]     d;
      logic           stop;
      expReg.delete();
      expData.delete();
      expPc.delete();
      pc = '0;
      stop = 1'b0;
      for (int step = 0; step < MAX_CYCLES && !stop; step++) begin
         w = imem[pc[8:1]];
         a = r[w[10:8]];
         b = r[w[7:5]];
         addr = a + {{11{w[4]}}, w[4:0]};
         expPc.push_back(pc);
         d = destOf(w);
         if (d[3]) begin
            r[d[2:0]] = valueOf(w, a, b, pc, m[addr[8:1]]);
            expReg.push_back(d[2:0]);
            expData.push_back(r[d[2:0]]);
         end
         if (w[15:11] == procPkg::OP_ST) m[addr[8:1]] = b;
         stop = (w[15:11] == procPkg::OP_HALT);
         pc = nextOf(w, a, pc);
      end
   endtask

   task automatic reportMismatch(input string sig, input procPkg::word_t exp,
         input procPkg::word_t got);
      $display("** Error at %0d ns: %s expected %h, got %h", $time, sig, exp, got);
      errors++;
   endtask

   task automatic reportProblem(input string msg);
      $display("error at %0d ns: %s", $time, msg);
      errors++;
   endtask

   // reset, trace until halt, then watch the halted core for a few cycles
   task automatic runProgram(input string name);
      int             cycle;
      int             writes;
      logic           done;
      procPkg::word_t holdAddr;
      errors = 0;
      runModel();
      @(posedge clk);
      #1 rstN = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rstN = 1'b1;
      cycle = 0;
      writes = 0;
      done = 1'b0;
      while (!done && cycle < MAX_CYCLES) begin
         // at mid-cycle the outputs show the instruction about to commit
         @(negedge clk);
         if (halted) begin
            done = 1'b1;
         end else begin
            if (cycle >= expPc.size()) begin
               reportProblem("core kept running past the expected HALT");
            end else if (imemAddr !== expPc[cycle]) begin
               reportMismatch("imemAddr", expPc[cycle], imemAddr);
            end
            if (wbEn) begin
               if (writes >= expReg.size()) begin
                  reportProblem($sformatf("unexpected register write to r%0d", wbReg));
               end else begin
                  if (wbReg !== expReg[writes]) begin
                     reportMismatch("wbReg", {13'b0, expReg[writes]}, {13'b0, wbReg});
                  end
                  // loads of never stored words come back unknown and are skipped
                  if (!$isunknown(expData[writes]) && wbData !== expData[writes]) begin
                     reportMismatch("wbData", expData[writes], wbData);
                  end
               end
               writes++;
            end
            cycle++;
         end
      end
      if (!done) begin
         reportProblem("core did not halt within the cycle limit");
      end else if (cycle != expPc.size() || writes != expReg.size()) begin
         reportProblem($sformatf("%0d instructions and %0d writes seen, %0d and %0d expected",
            cycle, writes, expPc.size(), expReg.size()));
      end
      if (done) begin
         holdAddr = imemAddr;
         if (holdAddr !== expPc[expPc.size() - 1]) begin
            reportMismatch("imemAddr", expPc[expPc.size() - 1], holdAddr);
         end
         // a writing instruction under the halted pc must neither write nor move the pc
         imem[holdAddr[8:1]] = byteForm(procPkg::OP_LBI, 3'd1, 8'h5a);
         repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (!halted) reportProblem("halted dropped without a reset");
            if (imemAddr !== holdAddr) reportMismatch("imemAddr", holdAddr, imemAddr);
            if (wbEn) reportProblem("register write after HALT");
         end
      end
      if (errors == 0) begin
         passCount++;
         $display("test %s: ok, %0d writes checked", name, writes);
      end else begin
         failCount++;
         $display("test %s: %0d errors", name, errors);
      end
   endtask

   task automatic testAlu();
      procPkg::word_t a, b, k;
      a = randWord();
      b = randWord();
      k = randWord();
      newProgram();
      loadConst(3'd1, a);
      loadConst(3'd2, b);
      put(immForm(procPkg::OP_ADDI, 3'd1, 3'd3, k[4:0]));
      put(immForm(procPkg::OP_SUBI, 3'd1, 3'd4, k[9:5]));
      put(immForm(procPkg::OP_XORI, 3'd2, 3'd5, k[14:10]));
      put(immForm(procPkg::OP_ANDNI, 3'd2, 3'd6, ~k[4:0]));
      put(regForm(procPkg::OP_ALU, 3'd1, 3'd2, 3'd3, 2'b00));
      put(regForm(procPkg::OP_ALU, 3'd1, 3'd2, 3'd4, 2'b01));
      put(regForm(procPkg::OP_ALU, 3'd1, 3'd2, 3'd5, 2'b10));
      put(regForm(procPkg::OP_ALU, 3'd1, 3'd2, 3'd6, 2'b11));
      // results fed back as operands
      put(regForm(procPkg::OP_ALU, 3'd3, 3'd4, 3'd7, 2'b01));
      put(jumpForm(procPkg::OP_HALT, 11'd0));
      runProgram("alu");
   endtask

   task automatic testCompare();
      procPkg::word_t x [4];
      procPkg::word_t y [4];
      x[0] = randWord();
      y[0] = randWord();
      x[1] = randWord();
      y[1] = x[1];
      // opposite signs
      x[2] = randWord() & 16'h7fff;
      y[2] = randWord() | 16'h8000;
      // both negative so the sum always carries
      x[3] = randWord() | 16'h8000;
      y[3] = randWord() | 16'h8000;
      newProgram();
      for (int p = 0; p < 4; p++) begin
         loadConst(3'd1, x[p]);
         loadConst(3'd2, y[p]);
         put(regForm(procPkg::OP_SEQ, 3'd1, 3'd2, 3'd3, 2'b00));
         put(regForm(procPkg::OP_SLT, 3'd1, 3'd2, 3'd4, 2'b00));
         put(regForm(procPkg::OP_SLE, 3'd1, 3'd2, 3'd5, 2'b00));
         put(regForm(procPkg::OP_SCO, 3'd1, 3'd2, 3'd6, 2'b00));
         put(regForm(procPkg::OP_SLT, 3'd2, 3'd1, 3'd7, 2'b00));
      end
      put(jumpForm(procPkg::OP_HALT, 11'd0));
      runProgram("compare");
   endtask

   task automatic testImmBtr();
      procPkg::word_t v;
      v = randWord();
      newProgram();
      put(byteForm(procPkg::OP_LBI, 3'd1, v[7:0]));
      put(byteForm(procPkg::OP_LBI, 3'd2, v[15:8] | 8'h80));
      put(byteForm(procPkg::OP_LBI, 3'd3, v[15:8] & 8'h7f));
      put(byteForm(procPkg::OP_SLBI, 3'd3, v[7:0]));
      put(byteForm(procPkg::OP_SLBI, 3'd2, ~v[7:0]));
      put(regForm(procPkg::OP_BTR, 3'd3, 3'd0, 3'd4, 2'b00));
      put(regForm(procPkg::OP_BTR, 3'd2, 3'd0, 3'd5, 2'b00));
      put(regForm(procPkg::OP_BTR, 3'd1, 3'd0, 3'd6, 2'b00));
      put(jumpForm(procPkg::OP_HALT, 11'd0));
      runProgram("immediate and btr");
   endtask

   task automatic testMemory();
      newProgram();
      loadConst(3'd1, randWord());
      // five neighbouring words at offsets -4 to 4 from the base
      for (int k = 0; k < 5; k++) begin
         loadConst(3'd2, randWord());
         put(immForm(procPkg::OP_ST, 3'd1, 3'd2, 5'(2 * k - 4)));
      end
      for (int k = 0; k < 5; k++) begin
         put(immForm(procPkg::OP_LD, 3'd1, 3'(3 + k), 5'(2 * k - 4)));
      end
      // overwrite one word and read it again
      loadConst(3'd2, randWord());
      put(immForm(procPkg::OP_ST, 3'd1, 3'd2, 5'd0));
      put(immForm(procPkg::OP_LD, 3'd1, 3'd3, 5'd0));
      put(jumpForm(procPkg::OP_HALT, 11'd0));
      runProgram("memory");
   endtask

   task automatic testBranch();
      procPkg::opcode_t kinds [4];
      procPkg::word_t   hit [4];
      procPkg::word_t   miss [4];
      procPkg::word_t   pos, neg;
      pos = (randWord() & 16'h7fff) | 16'h0001;
      neg = randWord() | 16'h8000;
      kinds = '{procPkg::OP_BEQZ, procPkg::OP_BNEZ, procPkg::OP_BLTZ, procPkg::OP_BGEZ};
      hit = '{16'h0000, neg, neg, pos};
      miss = '{pos, 16'h0000, pos, neg};
      newProgram();
      for (int k = 0; k < 4; k++) begin
         for (int t = 0; t < 2; t++) begin
            loadConst(3'd1, (t == 0) ? hit[k] : miss[k]);
            put(byteForm(kinds[k], 3'd1, 8'd2));
            // first marker is skipped when the branch is taken
            put(byteForm(procPkg::OP_LBI, 3'd2, 8'(16 * k + 2 * t)));
            put(byteForm(procPkg::OP_LBI, 3'd3, 8'(16 * k + 2 * t + 1)));
         end
      end
      // countdown loop on a backward branch
      put(byteForm(procPkg::OP_LBI, 3'd4, 8'd3));
      put(immForm(procPkg::OP_ADDI, 3'd4, 3'd4, 5'h1f));
      put(byteForm(procPkg::OP_BNEZ, 3'd4, 8'hfc));
      put(jumpForm(procPkg::OP_HALT, 11'd0));
      runProgram("branch");
   endtask

   task automatic testJumpHalt();
      procPkg::word_t v;
      v = randWord();
      newProgram();
      put(jumpForm(procPkg::OP_J, 11'd2));
      put(byteForm(procPkg::OP_LBI, 3'd1, 8'h55));
      put(byteForm(procPkg::OP_LBI, 3'd2, v[7:0]));
      // call to word 6 that links 8 into r7
      put(jumpForm(procPkg::OP_JAL, 11'd4));
      put(byteForm(procPkg::OP_LBI, 3'd3, v[15:8]));
      put(jumpForm(procPkg::OP_HALT, 11'd0));
      put(byteForm(procPkg::OP_LBI, 3'd4, ~v[7:0]));
      put(byteForm(procPkg::OP_JR, 3'd7, 8'd0));
      runProgram("jump and halt");
   endtask

   initial begin
      rstN = 1'b0;
      instr = {procPkg::OP_NOP, 11'd0};
      passCount = 0;
      failCount = 0;
      testAlu();
      testCompare();
      testImmBtr();
      testMemory();
      testBranch();
      testJumpHalt();
      $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   initial begin
      #WATCHDOG_NS;
      $display("watchdog: run still going after %0d ns, stopping", WATCHDOG_NS);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- tb.f
logic/procPkg.sv
logic/regFile.sv
logic/alu.sv
logic/decode.sv
logic/execute.sv
logic/result.sv
logic/proc.sv
test/proc_assertions.sv
test/procTb.sv

//--- Makefile
# Verilator lint and simulation of the single-cycle core testbench

VERILATOR ?= verilator
TOP       ?= procTb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Verification passed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
